// ==== vlog.f ====
+incdir+.
mem_pkg.sv
wb_pkg.sv
mem_reset_fsm.sv
mem_ram_sdp_core.sv
mem_ram_sdp.sv
wb_sdp_bridge.sv
mem_sdp_top.sv
tb_mem_sdp_top.sv

// ==== Bender.yml ====
package:
  name: mem_sdp

sources:
  - mem_pkg.sv
  - wb_pkg.sv
  - mem_reset_fsm.sv
  - mem_ram_sdp_core.sv
  - mem_ram_sdp.sv
  - wb_sdp_bridge.sv
  - mem_sdp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_sdp_top.sv

// ==== tb_mem_sdp_tasks.svh ====
// --------------------------------------------------------------------------
// Bus drivers, compare tasks and directed tests for the SDP RAM testbench
// Included inside the testbench module and driving inputs on the falling edge
// --------------------------------------------------------------------------
`ifndef TB_MEM_SDP_TASKS_SVH
`define TB_MEM_SDP_TASKS_SVH

task automatic check_rsp(input string name, input wb_pkg::wb_rsp_t got,
                         input wb_pkg::wb_rsp_t exp);
    if (got !== exp) begin
        $display("mismatch %s: got %h, expected %h", name, got, exp);
        report_failure();
    end
endtask

task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("mismatch %s: got %h, expected %h", name, got, exp);
        report_failure();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("mismatch %s: got %h, expected %h", name, got, exp);
        report_failure();
    end
endtask

// Selected bytes of wdat replace those of old
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdat,
                                            input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
        if (sel[i]) begin
            res[i*8 +: 8] = wdat[i*8 +: 8];
        end
    end
    return res;
endfunction

// --------------------------------------------------------------------------
// Bus drivers
// --------------------------------------------------------------------------
task automatic wb_write(input logic [5:0] adr, input logic [3:0] sel, input logic [31:0] dat);
    int cycles;
    cycles    = 0;
    wb_wr_req = wb_pkg::wb_wr_req_t'{cyc: 1'b1, stb: 1'b1, adr: adr, sel: sel, dat: dat};
    do begin
        @(negedge mem_wr_if);
        cycles++;
    end while (!wb_wr_rsp.ack);
    check_rsp("wb_wr_rsp", wb_wr_rsp, wb_pkg::wb_rsp_t'{ack: 1'b1, dat: '0});
    check_data("write ack latency", 32'(cycles), 32'd1);
    ref_mem[adr] = merge_bytes(ref_mem[adr], dat, sel);
    wb_wr_req    = '0;
    @(negedge mem_wr_if);
endtask

task automatic wb_read(input logic [5:0] adr);
    int cycles;
    cycles    = 0;
    wb_rd_req = wb_pkg::wb_rd_req_t'{cyc: 1'b1, stb: 1'b1, adr: adr};
    do begin
        @(negedge mem_wr_if);
        cycles++;
    end while (!wb_rd_rsp.ack);
    check_rsp("wb_rd_rsp", wb_rd_rsp, wb_pkg::wb_rsp_t'{ack: 1'b1, dat: ref_mem[adr]});
    check_data("read ack latency", 32'(cycles), 32'd3);
    wb_rd_req = '0;
    @(negedge mem_wr_if);
endtask

// Write and read start together and the read expects the word before the write
task automatic wr_rd_pair(input logic [5:0] wadr, input logic [3:0] sel,
                          input logic [31:0] dat, input logic [5:0] radr,
                          output int wr_cycles, output int rd_cycles, output int init_cycle);
    logic [31:0] old_dat;
    int          cycles;
    old_dat    = ref_mem[radr];
    cycles     = 0;
    wr_cycles  = 0;
    rd_cycles  = 0;
    init_cycle = 0;
    wb_wr_req  = wb_pkg::wb_wr_req_t'{cyc: 1'b1, stb: 1'b1, adr: wadr, sel: sel, dat: dat};
    wb_rd_req  = wb_pkg::wb_rd_req_t'{cyc: 1'b1, stb: 1'b1, adr: radr};
    while (wr_cycles == 0 || rd_cycles == 0) begin
        @(negedge mem_wr_if);
        cycles++;
        if (init_done && init_cycle == 0) begin
            init_cycle = cycles;
        end
        if (!init_done) begin
            check_flag("wb_wr_rsp.ack", wb_wr_rsp.ack, 1'b0);
            check_flag("wb_rd_rsp.ack", wb_rd_rsp.ack, 1'b0);
        end
        if (wr_cycles == 0 && wb_wr_rsp.ack) begin
            check_rsp("wb_wr_rsp", wb_wr_rsp, wb_pkg::wb_rsp_t'{ack: 1'b1, dat: '0});
            ref_mem[wadr] = merge_bytes(ref_mem[wadr], dat, sel);
            wb_wr_req     = '0;
            wr_cycles     = cycles;
        end
        if (rd_cycles == 0 && wb_rd_rsp.ack) begin
            check_rsp("wb_rd_rsp", wb_rd_rsp, wb_pkg::wb_rsp_t'{ack: 1'b1, dat: old_dat});
            wb_rd_req = '0;
            rd_cycles = cycles;
        end
    end
    @(negedge mem_wr_if);
endtask

// --------------------------------------------------------------------------
// Directed tests
// --------------------------------------------------------------------------

// Clear runs for 64 cycles and the write carries reset_val so contents stay clean
task automatic init_stall();
    int wc;
    int rc;
    int ic;
    check_flag("init_done", init_done, 1'b0);
    wr_rd_pair(6'd5, 4'hf, mem_pkg::reset_val, 6'd9, wc, rc, ic);
    check_data("init_done rise cycle", 32'(ic), 32'd64);
    check_data("stalled write ack cycle", 32'(wc), 32'd65);
    check_data("stalled read ack cycle", 32'(rc), 32'd67);
    check_flag("init_done", init_done, 1'b1);
endtask

// Every word still holds reset_val here
task automatic reset_sweep();
    for (int a = 0; a < mem_pkg::depth; a++) begin
        wb_read(6'(a));
    end
endtask

task automatic full_word_writes();
    logic [5:0] adr;
    for (int i = 0; i < 8; i++) begin
        adr = 6'(i * 7 + 3);
        wb_write(adr, 4'hf, (32'h0101_0101 * (i + 1)) ^ 32'ha5a5_0000);
        wb_read(adr);
    end
endtask

task automatic partial_writes();
    logic [35:0] sel_list;
    sel_list = {4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'h5, 4'ha, 4'h0};
    for (int i = 0; i < 9; i++) begin
        wb_write(6'd40, sel_list[i*4 +: 4], 32'h1122_3344 + 32'h1357_9bdf * i);
        wb_read(6'd40);
    end
endtask

task automatic same_cycle_rw();
    int wc;
    int rc;
    int ic;
    wr_rd_pair(6'd17, 4'hf, 32'h0bad_f00d, 6'd17, wc, rc, ic);
    check_data("same-cycle write ack cycle", 32'(wc), 32'd1);
    check_data("same-cycle read ack cycle", 32'(rc), 32'd3);
    wb_read(6'd17);
endtask

task automatic random_traffic();
    logic [31:0] r;
    for (int n = 0; n < n_random; n++) begin
        r = $urandom;
        if (r[0]) begin
            wb_write(6'($urandom), 4'($urandom), $urandom);
        end else begin
            wb_read(6'($urandom));
        end
    end
endtask

`endif

// ==== tb_mem_sdp_top.sv ====
// --------------------------------------------------------------------------
// Testbench for the Wishbone SDP RAM top level with clock, reset, DUT,
// reference model, timeout and the directed test sequence
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_mem_sdp_top;

    localparam int          n_random = 300;
    localparam logic [31:0] seed     = 32'ha2497a24;
    // Worst case per transfer with its idle cycle is 2 for a write and 4 for a read
    localparam int test_cycles    = 8 + 70 + 64 * 4 + 17 * 6 + 10 + n_random * 4;
    localparam int timeout_cycles = 2 * test_cycles + 500;

    logic               mem_wr_if;
    logic               rst_n;
    wb_pkg::wb_wr_req_t wb_wr_req;
    wb_pkg::wb_rsp_t    wb_wr_rsp;
    wb_pkg::wb_rd_req_t wb_rd_req;
    wb_pkg::wb_rsp_t    wb_rd_rsp;
    logic               init_done;

    // Expected RAM contents updated on every acknowledged write
    logic [mem_pkg::data_wid-1:0] ref_mem [mem_pkg::depth];
    int                           cycle_cnt = 0;

    mem_sdp_top i_mem_sdp_top (
        .mem_wr_if (mem_wr_if),
        .rst_n     (rst_n),
        .wb_wr_req (wb_wr_req),
        .wb_wr_rsp (wb_wr_rsp),
        .wb_rd_req (wb_rd_req),
        .wb_rd_rsp (wb_rd_rsp),
        .init_done (init_done)
    );

    initial begin
        mem_wr_if = 1'b0;
        forever #4 mem_wr_if = ~mem_wr_if;
    end

    task automatic report_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge mem_wr_if) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", timeout_cycles);
            report_failure();
        end
    end

    `include "tb_mem_sdp_tasks.svh"

    initial begin
        rst_n     = 1'b0;
        wb_wr_req = '0;
        wb_rd_req = '0;
        void'($urandom(seed));
        for (int a = 0; a < mem_pkg::depth; a++) begin
            ref_mem[a] = mem_pkg::reset_val;
        end
        repeat (8) @(negedge mem_wr_if);
        rst_n = 1'b1;
        init_stall();
        reset_sweep();
        full_word_writes();
        partial_writes();
        same_cycle_rw();
        random_traffic();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_sdp_top.sv ====
// --------------------------------------------------------------------------
// Top level: Wishbone write and read ports in front of the reset-cleared
// SDP RAM block
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_sdp_top (
    input  logic               mem_wr_if,
    input  logic               rst_n,
    input  wb_pkg::wb_wr_req_t wb_wr_req,
    output wb_pkg::wb_rsp_t    wb_wr_rsp,
    input  wb_pkg::wb_rd_req_t wb_rd_req,
    output wb_pkg::wb_rsp_t    wb_rd_rsp,
    output logic               init_done
);

    // Bridge to RAM
    mem_pkg::mem_wr_req_t wr_req;
    mem_pkg::mem_rd_req_t rd_req;
    mem_pkg::mem_rd_rsp_t rd_rsp;

    wb_sdp_bridge i_wb_sdp_bridge (
        .mem_wr_if (mem_wr_if),
        .rst_n     (rst_n),
        .wb_wr_req (wb_wr_req),
        .wb_wr_rsp (wb_wr_rsp),
        .wb_rd_req (wb_rd_req),
        .wb_rd_rsp (wb_rd_rsp),
        .init_done (init_done),
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp)
    );

    mem_ram_sdp i_mem_ram_sdp (
        .mem_wr_if (mem_wr_if),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp),
        .init_done (init_done)
    );

endmodule

`default_nettype wire

// ==== wb_sdp_bridge.sv ====
// --------------------------------------------------------------------------
// Two Wishbone classic slave ports, one write and one read, each turned
// into single-cycle RAM requests with one ack per transfer
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wb_sdp_bridge (
    input  logic                 mem_wr_if,
    input  logic                 rst_n,
    input  wb_pkg::wb_wr_req_t   wb_wr_req,
    output wb_pkg::wb_rsp_t      wb_wr_rsp,
    input  wb_pkg::wb_rd_req_t   wb_rd_req,
    output wb_pkg::wb_rsp_t      wb_rd_rsp,
    input  logic                 init_done,
    output mem_pkg::mem_wr_req_t wr_req,
    output mem_pkg::mem_rd_req_t rd_req,
    input  mem_pkg::mem_rd_rsp_t rd_rsp
);

    typedef enum logic {
        rd_idle,
        rd_wait
    } rd_state_t;

    logic                         wr_issue;
    logic                         wr_ack_q;

    rd_state_t                    rd_state;
    logic                         rd_issue;
    logic                         rd_ack_q;
    logic [mem_pkg::data_wid-1:0] rd_dat_q;

    // ----------------------------------------------------------------------
    // Write port
    // ----------------------------------------------------------------------

    // A strobe still held during its ack cycle must not write again
    assign wr_issue = wb_wr_req.cyc & wb_wr_req.stb & init_done & ~wr_ack_q;

    assign wr_req = '{
        valid: wr_issue,
        addr:  wb_wr_req.adr,
        be:    wb_wr_req.sel,
        data:  wb_wr_req.dat
    };

    always_ff @(posedge mem_wr_if) begin
        if (!rst_n) begin
            wr_ack_q <= 1'b0;
        end else begin
            wr_ack_q <= wr_issue;
        end
    end

    assign wb_wr_rsp = '{ack: wr_ack_q, dat: '0};

    // ----------------------------------------------------------------------
    // Read port
    // ----------------------------------------------------------------------
    assign rd_issue = (rd_state == rd_idle) & wb_rd_req.cyc & wb_rd_req.stb
                    & init_done & ~rd_ack_q;

    assign rd_req = '{valid: rd_issue, addr: wb_rd_req.adr};

    always_ff @(posedge mem_wr_if) begin
        if (!rst_n) begin
            rd_state <= rd_idle;
            rd_ack_q <= 1'b0;
        end else begin
            rd_ack_q <= 1'b0;
            case (rd_state)
                rd_idle: begin
                    if (rd_issue) begin
                        rd_state <= rd_wait;
                    end
                end
                default: begin
                    // Ack goes out the cycle after the RAM answers
                    if (rd_rsp.valid) begin
                        rd_ack_q <= 1'b1;
                        rd_state <= rd_idle;
                    end
                end
            endcase
        end
    end

    // Held for the ack cycle
    always_ff @(posedge mem_wr_if) begin
        if (rd_rsp.valid) begin
            rd_dat_q <= rd_rsp.data;
        end
    end

    assign wb_rd_rsp = '{ack: rd_ack_q, dat: rd_dat_q};

    a_wr_ack_single : assert property (
        @(posedge mem_wr_if) disable iff (!rst_n)
        wb_wr_rsp.ack |=> !wb_wr_rsp.ack
    ) else $error("write ack high for two cycles");

    a_rd_ack_single : assert property (
        @(posedge mem_wr_if) disable iff (!rst_n)
        wb_rd_rsp.ack |=> !wb_rd_rsp.ack
    ) else $error("read ack high for two cycles");

    // Next read only after the RAM has answered the previous one
    a_rd_one_outstanding : assert property (
        @(posedge mem_wr_if) disable iff (!rst_n)
        rd_req.valid |=> !rd_req.valid until_with rd_rsp.valid
    ) else $error("read issued while another is outstanding");

endmodule

`default_nettype wire

// ==== mem_ram_sdp.sv ====
// --------------------------------------------------------------------------
// Reset-cleared SDP RAM block: the clear sequencer in front of the storage
// core, with reads held back until the clear has finished
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_ram_sdp (
    input  logic                 mem_wr_if,
    input  logic                 rst_n,
    input  mem_pkg::mem_wr_req_t wr_req,
    input  mem_pkg::mem_rd_req_t rd_req,
    output mem_pkg::mem_rd_rsp_t rd_rsp,
    output logic                 init_done
);

    // Requests as seen by the storage core
    mem_pkg::mem_wr_req_t core_wr_req;
    mem_pkg::mem_rd_req_t core_rd_req;

    // ----------------------------------------------------------------------
    // Clear sequencer
    // ----------------------------------------------------------------------
    mem_reset_fsm i_mem_reset_fsm (
        .mem_wr_if  (mem_wr_if),
        .rst_n      (rst_n),
        .wr_req_in  (wr_req),
        .wr_req_out (core_wr_req),
        .init_done  (init_done)
    );

    // ----------------------------------------------------------------------
    // Read gate
    // ----------------------------------------------------------------------

    // No read reaches the array mid-clear
    assign core_rd_req = '{
        valid: rd_req.valid & init_done,
        addr:  rd_req.addr
    };

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------
    mem_ram_sdp_core i_mem_ram_sdp_core (
        .mem_wr_if (mem_wr_if),
        .rst_n     (rst_n),
        .wr_req    (core_wr_req),
        .rd_req    (core_rd_req),
        .rd_rsp    (rd_rsp)
    );

endmodule

`default_nettype wire

// ==== mem_ram_sdp_core.sv ====
// --------------------------------------------------------------------------
// 64x32 simple dual-port storage with byte-enable writes and a read-first,
// two-stage registered read path
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_ram_sdp_core (
    input  logic                 mem_wr_if,
    input  logic                 rst_n,
    input  mem_pkg::mem_wr_req_t wr_req,
    input  mem_pkg::mem_rd_req_t rd_req,
    output mem_pkg::mem_rd_rsp_t rd_rsp
);

    logic [mem_pkg::data_wid-1:0] mem [mem_pkg::depth];

    // Read pipeline
    logic                         rd_vld_q;
    logic [mem_pkg::data_wid-1:0] rd_data_q;
    logic                         rsp_vld_q;
    logic [mem_pkg::data_wid-1:0] rsp_data_q;

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------
    always_ff @(posedge mem_wr_if) begin
        if (wr_req.valid) begin
            for (int i = 0; i < mem_pkg::be_wid; i++) begin
                if (wr_req.be[i]) begin
                    mem[wr_req.addr][i*8 +: 8] <= wr_req.data[i*8 +: 8];
                end
            end
        end
    end

    // Array read samples the old word when the same address is written
    always_ff @(posedge mem_wr_if) begin
        if (rd_req.valid) begin
            rd_data_q <= mem[rd_req.addr];
        end
        rsp_data_q <= rd_data_q;
    end

    // Valid travels with the data
    always_ff @(posedge mem_wr_if) begin
        if (!rst_n) begin
            rd_vld_q  <= 1'b0;
            rsp_vld_q <= 1'b0;
        end else begin
            rd_vld_q  <= rd_req.valid;
            rsp_vld_q <= rd_vld_q;
        end
    end

    assign rd_rsp = '{valid: rsp_vld_q, data: rsp_data_q};

    a_rd_latency : assert property (
        @(posedge mem_wr_if) disable iff (!rst_n)
        rd_req.valid |-> ##(mem_pkg::rd_latency) rd_rsp.valid
    ) else $error("read response missing after request");

    a_rd_no_spurious : assert property (
        @(posedge mem_wr_if) disable iff (!rst_n)
        rd_rsp.valid |-> $past(rd_req.valid, mem_pkg::rd_latency)
    ) else $error("read response without matching request");

endmodule

`default_nettype wire

// ==== mem_reset_fsm.sv ====
// --------------------------------------------------------------------------
// Clears every RAM word to the reset value after reset, then hands the
// write port over to the user and reports init_done
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_reset_fsm (
    input  logic                 mem_wr_if,
    input  logic                 rst_n,
    input  mem_pkg::mem_wr_req_t wr_req_in,
    output mem_pkg::mem_wr_req_t wr_req_out,
    output logic                 init_done
);

    typedef enum logic {
        st_clearing,
        st_ready
    } state_t;

    state_t                        state;
    logic [mem_pkg::addr_wid-1:0]  clr_addr;
    logic                          clr_last;

    // Last word of the clear sweep
    assign clr_last = (clr_addr == mem_pkg::addr_wid'(mem_pkg::depth - 1));

    // ----------------------------------------------------------------------
    // State and address counter
    // ----------------------------------------------------------------------
    always_ff @(posedge mem_wr_if) begin
        if (!rst_n) begin
            state    <= st_clearing;
            clr_addr <= '0;
        end else begin
            case (state)
                st_clearing: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_last) begin
                        state <= st_ready;
                    end
                end
                default: begin
                    // Stays here until the next reset
                    state <= st_ready;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Write request mux
    // ----------------------------------------------------------------------
    always_comb begin
        if (state == st_clearing) begin
            // Full word of reset_val, user request dropped
            wr_req_out.valid = 1'b1;
            wr_req_out.addr  = clr_addr;
            wr_req_out.be    = '1;
            wr_req_out.data  = mem_pkg::reset_val;
        end else begin
            wr_req_out = wr_req_in;
        end
    end

    assign init_done = (state == st_ready);

    // Upstream logic has to hold writes off until init_done
    a_no_user_wr_while_clearing : assert property (
        @(posedge mem_wr_if) disable iff (!rst_n)
        (state == st_clearing) |-> !wr_req_in.valid
    ) else $error("user write issued during clear sequence");

endmodule

`default_nettype wire

// ==== wb_pkg.sv ====
// --------------------------------------------------------------------------
// Wishbone classic widths and bus signal groups for the two slave ports
// --------------------------------------------------------------------------
`default_nettype none

package wb_pkg;

    // Word addressed bus
    localparam int wb_adr_wid = 6;
    localparam int wb_dat_wid = 32;
    localparam int wb_sel_wid = wb_dat_wid / 8;

    // ----------------------------------------------------------------------
    // Master to slave
    // ----------------------------------------------------------------------

    // Write bus
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic [wb_adr_wid-1:0] adr;
        logic [wb_sel_wid-1:0] sel;
        logic [wb_dat_wid-1:0] dat;
    } wb_wr_req_t;

    // Read bus, no data or selects
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic [wb_adr_wid-1:0] adr;
    } wb_rd_req_t;

    // ----------------------------------------------------------------------
    // Slave to master, same shape on both buses
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic                  ack;
        logic [wb_dat_wid-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
// --------------------------------------------------------------------------
// RAM geometry and request/response types shared by the SDP RAM block
// Referenced by scoped name from the RAM modules, the bridge and the top
// --------------------------------------------------------------------------
`default_nettype none

package mem_pkg;

    // Geometry
    localparam int addr_wid = 6;
    localparam int data_wid = 32;
    localparam int be_wid   = data_wid / 8;
    localparam int depth    = 2 ** addr_wid;

    // Value left in every word by the clear sequence
    localparam logic [data_wid-1:0] reset_val = 32'hdead_beef;

    // Request to response, in clock cycles
    localparam int rd_latency = 2;

    // ----------------------------------------------------------------------
    // Request and response words
    // ----------------------------------------------------------------------

    // Write request, one cycle per word
    typedef struct packed {
        logic                valid;
        logic [addr_wid-1:0] addr;
        logic [be_wid-1:0]   be;
        logic [data_wid-1:0] data;
    } mem_wr_req_t;

    typedef struct packed {
        logic                valid;
        logic [addr_wid-1:0] addr;
    } mem_rd_req_t;

    // Valid comes back rd_latency cycles after the request
    typedef struct packed {
        logic                valid;
        logic [data_wid-1:0] data;
    } mem_rd_rsp_t;

endpackage

`default_nettype wire
